// ==== src/nts_extractor_pkg.sv ====
// Ring geometry is fixed at four slots of 256 words and a packet must fit in one slot
package nts_extractor_pkg;

  // ----------------------------------------
  // Widths and plain vector types
  // ----------------------------------------
  localparam int SLOT_BITS      = 2;
  localparam int WORD_ADDR_BITS = 8;
  localparam int RAM_ADDR_BITS  = SLOT_BITS + WORD_ADDR_BITS;

  typedef logic [63:0]               word_t;
  // Valid bytes in the last word, 1 to 8
  typedef logic [3:0]                byte_count_t;
  // Bit 0 is the first byte on the MAC
  typedef logic [7:0]                byte_mask_t;
  typedef logic [SLOT_BITS-1:0]      slot_t;
  typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;
  typedef logic [RAM_ADDR_BITS-1:0]  ram_addr_t;

  // ----------------------------------------
  // State machines
  // ----------------------------------------
  typedef enum logic [1:0] {
    SLOT_UNUSED  = 2'b00,
    SLOT_WRITING = 2'b01,
    SLOT_LOADED  = 2'b10,
    SLOT_READING = 2'b11
  } slot_state_e;

  typedef enum logic {MUX_SEARCH, MUX_REMAIN} mux_state_e;
  typedef enum logic {RD_IDLE, RD_READING} reader_state_e;
  typedef enum logic [1:0] {TX_IDLE, TX_AWAIT_ACK, TX_WRITE, TX_SILENT} tx_state_e;

  // ----------------------------------------
  // Port bundles
  // ----------------------------------------
  typedef struct packed {
    logic        packet_available;
    logic        fifo_empty;
    logic        rd_valid;
    word_t       rd_data;
    byte_count_t bytes_last_word;
  } engine_if_t;

  typedef struct packed {
    logic        start;
    logic        stop;
    logic        data_valid;
    word_t       data;
    byte_count_t bytes_last_word;
  } reader_out_t;

  typedef struct packed {
    logic       start;
    slot_t      slot;
    word_addr_t last;
    byte_mask_t last_mask;
  } tx_job_t;

endpackage

// ==== src/engine_mux.sv ====
// Engines must drop packet_available within a cycle of the packet_read pulse
`timescale 1ns/1ps

module engine_mux
  import nts_extractor_pkg::*;
#(
  parameter int ENGINES = 4
) (
  input  logic                     i_clk,
  input  logic                     i_areset,
  input  engine_if_t [ENGINES-1:0] i_engines,
  input  logic                     i_rd_start,
  input  logic                     i_packet_read,
  output engine_if_t               o_selected,
  output logic       [ENGINES-1:0] o_engine_fifo_rd_start,
  output logic       [ENGINES-1:0] o_engine_packet_read
);

  localparam int IDX_BITS = (ENGINES > 1) ? $clog2(ENGINES) : 1;
  localparam logic [IDX_BITS-1:0] IDX_LAST = IDX_BITS'(ENGINES - 1);

  logic [ENGINES-1:0]  ready_d;
  logic [ENGINES-1:0]  ready_q;
  logic [IDX_BITS-1:0] search_idx_d;
  logic [IDX_BITS-1:0] search_idx_q;
  logic                found_d;
  logic                found_q;
  logic [IDX_BITS-1:0] sel_idx_q;
  mux_state_e          state_d;
  mux_state_e          state_q;
  logic                start_search;
  logic                forward;

  function automatic logic [IDX_BITS-1:0] prev_idx(logic [IDX_BITS-1:0] idx);
    return (idx == '0) ? IDX_LAST : idx - 1'b1;
  endfunction

  // ----------------------------------------
  // Search register
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < ENGINES; i++) begin
      ready_d[i] = i_engines[i].packet_available && !i_engines[i].fifo_empty;
    end
  end

  always_comb begin
    logic hit;
    hit = ready_q[search_idx_q];
    // Never pick the engine that is being served
    if (state_q == MUX_REMAIN && search_idx_q == sel_idx_q) begin
      hit = 1'b0;
    end
    found_d      = hit;
    search_idx_d = hit ? search_idx_q : prev_idx(search_idx_q);
    if (start_search) begin
      found_d      = 1'b0;
      search_idx_d = prev_idx(sel_idx_q);
    end
  end

  // ----------------------------------------
  // Selection
  // ----------------------------------------
  always_comb begin
    state_d      = state_q;
    start_search = 1'b0;
    forward      = 1'b0;
    o_selected   = '0;
    case (state_q)
      MUX_REMAIN: begin
        o_selected = i_engines[sel_idx_q];
        if (i_packet_read) begin
          state_d = MUX_SEARCH;
          forward = 1'b1;
        end
      end
      default: begin
        if (ready_d[sel_idx_q]) begin
          state_d      = MUX_REMAIN;
          start_search = 1'b1;
        end else begin
          forward = 1'b1;
        end
      end
    endcase
  end

  // Pulses from the reader go to the selected engine only
  always_comb begin
    o_engine_fifo_rd_start            = '0;
    o_engine_packet_read              = '0;
    o_engine_fifo_rd_start[sel_idx_q] = i_rd_start;
    o_engine_packet_read[sel_idx_q]   = i_packet_read;
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      ready_q      <= '0;
      search_idx_q <= '0;
      found_q      <= 1'b0;
      sel_idx_q    <= '0;
      state_q      <= MUX_SEARCH;
    end else begin
      ready_q      <= ready_d;
      search_idx_q <= search_idx_d;
      found_q      <= found_d;
      state_q      <= state_d;
      if (forward && found_q) begin
        sel_idx_q <= search_idx_q;
      end
    end
  end

  // The reader only releases an engine that the mux is still holding
  assert property (@(posedge i_clk) disable iff (i_areset)
    i_packet_read |-> state_q == MUX_REMAIN);

endmodule

// ==== src/engine_reader.sv ====
// A read starts only while the selected FIFO is not empty and a slot is free
`timescale 1ns/1ps

module engine_reader
  import nts_extractor_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_areset,
  input  engine_if_t  i_selected,
  input  logic        i_slot_free,
  output logic        o_rd_start,
  output logic        o_packet_read,
  output reader_out_t o_word
);

  reader_state_e state_q;
  logic          rd_start_q;
  logic          packet_read_q;
  logic          stop_q;
  logic          valid_q;
  word_t         data_q;
  byte_count_t   lwdv_q;
  logic          begin_read;

  // Hold off for one cycle after a release so the mux can move on
  assign begin_read = state_q == RD_IDLE && i_selected.packet_available &&
                      !i_selected.fifo_empty && i_slot_free && !packet_read_q;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q       <= RD_IDLE;
      rd_start_q    <= 1'b0;
      packet_read_q <= 1'b0;
      stop_q        <= 1'b0;
      valid_q       <= 1'b0;
    end else begin
      rd_start_q    <= begin_read;
      packet_read_q <= 1'b0;
      stop_q        <= 1'b0;
      valid_q       <= 1'b0;
      if (begin_read) begin
        state_q <= RD_READING;
      end
      if (state_q == RD_READING) begin
        if (i_selected.rd_valid) begin
          valid_q <= 1'b1;
        end else if (i_selected.fifo_empty) begin
          // FIFO ran dry so the packet is complete
          packet_read_q <= 1'b1;
          stop_q        <= 1'b1;
          state_q       <= RD_IDLE;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (begin_read) begin
      lwdv_q <= i_selected.bytes_last_word;
    end
    if (state_q == RD_READING && i_selected.rd_valid) begin
      data_q <= i_selected.rd_data;
    end
  end

  assign o_rd_start    = rd_start_q;
  assign o_packet_read = packet_read_q;
  assign o_word        = '{start: rd_start_q, stop: stop_q, data_valid: valid_q,
                           data: data_q, bytes_last_word: lwdv_q};

endmodule

// ==== src/tx_slot_ring.sv ====
// Slots are filled and drained strictly in ring order and each holds at most 256 words
`timescale 1ns/1ps

module tx_slot_ring
  import nts_extractor_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_areset,
  input  reader_out_t i_word,
  input  ram_addr_t   i_rd_addr,
  input  logic        i_done,
  input  logic        i_idle,
  output logic        o_slot_free,
  output tx_job_t     o_job,
  output word_t       o_rd_data
);

  localparam int SLOTS = 2 ** SLOT_BITS;

  word_t       ram [2 ** RAM_ADDR_BITS];
  slot_state_e state_q [SLOTS];
  word_addr_t  count_q [SLOTS];
  byte_count_t lwdv_q [SLOTS];
  slot_t       wr_slot_q;
  slot_t       rd_slot_q;
  logic        wr_en_q;
  ram_addr_t   wr_addr_q;
  word_t       wr_data_q;
  logic        take_word;

  // Count of 1..8 becomes a run of ones from bit 0
  function automatic byte_mask_t expand_mask(byte_count_t n);
    byte_mask_t m;
    for (int i = 0; i < 8; i++) begin
      m[i] = 4'(i) < n;
    end
    return m;
  endfunction

  assign take_word   = state_q[wr_slot_q] == SLOT_WRITING && i_word.data_valid;
  assign o_slot_free = state_q[wr_slot_q] == SLOT_UNUSED;

  always_comb begin
    o_job.start     = state_q[rd_slot_q] == SLOT_LOADED && i_idle;
    o_job.slot      = rd_slot_q;
    o_job.last      = count_q[rd_slot_q] - 1'b1;
    o_job.last_mask = expand_mask(lwdv_q[rd_slot_q]);
  end

  // ----------------------------------------
  // Slot states and ring pointers
  // ----------------------------------------
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      for (int i = 0; i < SLOTS; i++) begin
        state_q[i] <= SLOT_UNUSED;
      end
      wr_slot_q <= '0;
      rd_slot_q <= '0;
      wr_en_q   <= 1'b0;
    end else begin
      wr_en_q <= take_word;
      if (state_q[wr_slot_q] == SLOT_UNUSED && i_word.start) begin
        state_q[wr_slot_q] <= SLOT_WRITING;
      end else if (state_q[wr_slot_q] == SLOT_WRITING && i_word.stop) begin
        state_q[wr_slot_q] <= SLOT_LOADED;
        wr_slot_q          <= wr_slot_q + 1'b1;
      end
      // Read side only touches LOADED or READING slots
      if (o_job.start) begin
        state_q[rd_slot_q] <= SLOT_READING;
      end else if (state_q[rd_slot_q] == SLOT_READING && i_done) begin
        state_q[rd_slot_q] <= SLOT_UNUSED;
        rd_slot_q          <= rd_slot_q + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Write stage and RAM
  // ----------------------------------------
  always_ff @(posedge i_clk) begin
    if (state_q[wr_slot_q] == SLOT_UNUSED && i_word.start) begin
      count_q[wr_slot_q] <= '0;
      lwdv_q[wr_slot_q]  <= i_word.bytes_last_word;
    end
    if (take_word) begin
      count_q[wr_slot_q] <= count_q[wr_slot_q] + 1'b1;
      wr_addr_q          <= {wr_slot_q, count_q[wr_slot_q]};
      wr_data_q          <= i_word.data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_en_q) begin
      ram[wr_addr_q] <= wr_data_q;
    end
  end

  assign o_rd_data = ram[i_rd_addr];

  // Registered writes must still land in a slot that is being filled
  assert property (@(posedge i_clk) disable iff (i_areset)
    wr_en_q |-> state_q[wr_addr_q[RAM_ADDR_BITS-1 -: SLOT_BITS]] == SLOT_WRITING);

endmodule

// ==== src/mac_tx.sv ====
// Word 0 is held until the MAC acknowledges and later words get no back-pressure
`timescale 1ns/1ps

module mac_tx
  import nts_extractor_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_areset,
  input  tx_job_t    i_job,
  input  word_t      i_rd_data,
  input  logic       i_mac_tx_ack,
  output ram_addr_t  o_rd_addr,
  output logic       o_done,
  output logic       o_idle,
  output logic       o_mac_tx_start,
  output byte_mask_t o_mac_tx_data_valid,
  output word_t      o_mac_tx_data
);

  tx_state_e  state_q;
  slot_t      slot_q;
  word_addr_t ptr_q;
  word_addr_t last_q;
  byte_mask_t mask_q;
  logic       start_q;
  logic       done_q;
  byte_mask_t valid_q;
  word_t      data_q;
  logic       advance;
  logic       is_last;
  byte_mask_t emit_mask;

  // First RAM byte lands in lane 0 and masked lanes read as zero
  function automatic word_t reverse_bytes(word_t w, byte_mask_t m);
    word_t r;
    for (int i = 0; i < 8; i++) begin
      r[8*i +: 8] = m[i] ? w[8*(7-i) +: 8] : 8'h00;
    end
    return r;
  endfunction

  assign advance   = (state_q == TX_AWAIT_ACK && i_mac_tx_ack) || state_q == TX_WRITE;
  assign is_last   = ptr_q == last_q;
  assign emit_mask = is_last ? mask_q : '1;
  assign o_idle    = state_q == TX_IDLE;

  // Word 0 is addressed straight from the job while idle
  assign o_rd_addr = o_idle ? {i_job.slot, WORD_ADDR_BITS'(0)} : {slot_q, ptr_q};

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q <= TX_IDLE;
      slot_q  <= '0;
      ptr_q   <= '0;
      last_q  <= '0;
      mask_q  <= '0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
      valid_q <= '0;
      data_q  <= '0;
    end else begin
      start_q <= 1'b0;
      done_q  <= 1'b0;
      case (state_q)
        TX_IDLE: begin
          valid_q <= '0;
          data_q  <= '0;
          if (i_job.start) begin
            start_q <= 1'b1;
            valid_q <= '1;
            data_q  <= reverse_bytes(i_rd_data, '1);
            slot_q  <= i_job.slot;
            last_q  <= i_job.last;
            mask_q  <= i_job.last_mask;
            ptr_q   <= WORD_ADDR_BITS'(1);
            state_q <= TX_AWAIT_ACK;
          end
        end
        TX_SILENT: begin
          // One empty cycle marks the end of the packet
          valid_q <= '0;
          data_q  <= '0;
          state_q <= TX_IDLE;
        end
        default: ;
      endcase
      if (advance) begin
        valid_q <= emit_mask;
        data_q  <= reverse_bytes(i_rd_data, emit_mask);
        if (is_last) begin
          done_q  <= 1'b1;
          state_q <= TX_SILENT;
        end else begin
          ptr_q   <= ptr_q + 1'b1;
          state_q <= TX_WRITE;
        end
      end
    end
  end

  assign o_done              = done_q;
  assign o_mac_tx_start      = start_q;
  assign o_mac_tx_data_valid = valid_q;
  assign o_mac_tx_data       = data_q;

  // Mask from the slot ring must be contiguous from lane 0
  assert property (@(posedge i_clk) disable iff (i_areset)
    (o_mac_tx_data_valid & (o_mac_tx_data_valid + 8'd1)) == 8'd0);

endmodule

// ==== src/nts_extractor.sv ====
// Engines follow the available, rd_start and packet_read handshake, one packet per read
`timescale 1ns/1ps

module nts_extractor
  import nts_extractor_pkg::*;
#(
  parameter int ENGINES = 4
) (
  input  logic                     i_clk,
  input  logic                     i_areset,
  input  engine_if_t [ENGINES-1:0] i_engines,
  output logic       [ENGINES-1:0] o_engine_fifo_rd_start,
  output logic       [ENGINES-1:0] o_engine_packet_read,
  output logic                     o_mac_tx_start,
  input  logic                     i_mac_tx_ack,
  output byte_mask_t               o_mac_tx_data_valid,
  output word_t                    o_mac_tx_data
);

  engine_if_t  selected;
  logic        rd_start;
  logic        packet_read;
  reader_out_t reader_word;
  logic        slot_free;
  tx_job_t     job;
  word_t       rd_data;
  ram_addr_t   rd_addr;
  logic        tx_done;
  logic        tx_idle;

  // ----------------------------------------
  // Engine side
  // ----------------------------------------
  engine_mux #(
    .ENGINES(ENGINES)
  ) engine_mux_inst (
    .i_clk                  (i_clk),
    .i_areset               (i_areset),
    .i_engines              (i_engines),
    .i_rd_start             (rd_start),
    .i_packet_read          (packet_read),
    .o_selected             (selected),
    .o_engine_fifo_rd_start (o_engine_fifo_rd_start),
    .o_engine_packet_read   (o_engine_packet_read)
  );

  engine_reader engine_reader_inst (
    .i_clk         (i_clk),
    .i_areset      (i_areset),
    .i_selected    (selected),
    .i_slot_free   (slot_free),
    .o_rd_start    (rd_start),
    .o_packet_read (packet_read),
    .o_word        (reader_word)
  );

  // ----------------------------------------
  // Buffer and MAC side
  // ----------------------------------------
  tx_slot_ring tx_slot_ring_inst (
    .i_clk       (i_clk),
    .i_areset    (i_areset),
    .i_word      (reader_word),
    .i_rd_addr   (rd_addr),
    .i_done      (tx_done),
    .i_idle      (tx_idle),
    .o_slot_free (slot_free),
    .o_job       (job),
    .o_rd_data   (rd_data)
  );

  mac_tx mac_tx_inst (
    .i_clk               (i_clk),
    .i_areset            (i_areset),
    .i_job               (job),
    .i_rd_data           (rd_data),
    .i_mac_tx_ack        (i_mac_tx_ack),
    .o_rd_addr           (rd_addr),
    .o_done              (tx_done),
    .o_idle              (tx_idle),
    .o_mac_tx_start      (o_mac_tx_start),
    .o_mac_tx_data_valid (o_mac_tx_data_valid),
    .o_mac_tx_data       (o_mac_tx_data)
  );

endmodule

// ==== sim/extractor_checker.sv ====
// Engine words are taken as they stream in, so a packet must not reach the MAC before its stream ends
`timescale 1ns/1ps

module extractor_checker
  import nts_extractor_pkg::*;
#(
  parameter int ENGINES = 4
) (
  input  logic                     i_clk,
  input  logic                     i_areset,
  input  engine_if_t [ENGINES-1:0] i_engines,
  input  logic       [ENGINES-1:0] i_engine_fifo_rd_start,
  input  logic       [ENGINES-1:0] i_engine_packet_read,
  input  logic                     i_mac_tx_start,
  input  logic                     i_mac_tx_ack,
  input  byte_mask_t               i_mac_tx_data_valid,
  input  word_t                    i_mac_tx_data,
  output int                       o_errors,
  output int                       o_packets
);

  word_t       exp_words [ENGINES][$];
  int          exp_len [ENGINES][$];
  byte_count_t exp_lwdv [ENGINES][$];
  int          stream_cnt [ENGINES];
  logic        busy [ENGINES];
  int          busy_cnt;
  word_t       got_words [$];
  byte_mask_t  got_masks [$];
  logic        collecting;
  logic        holding;
  word_t       first_word;

  // First n source bytes go to lanes 0..n-1 in reverse order
  function automatic word_t swap_byte_order(word_t w, int n);
    word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r[8*i +: 8] = w[56-8*i +: 8];
    end
    return r;
  endfunction

  function automatic byte_mask_t low_ones(int n);
    logic [8:0] m;
    m = (9'd1 << n) - 9'd1;
    return m[7:0];
  endfunction

  task automatic compare_packet();
    int          e;
    int          len;
    int          n;
    byte_count_t lwdv;
    word_t       src;
    word_t       exp_data;
    byte_mask_t  exp_mask;
    // Engine number sits in the last lane of word 0
    e = int'(got_words[0][63:56]);
    if (e >= ENGINES || exp_len[e].size() == 0) begin
      o_errors++;
      $display("Unexpected extra packet seen for engine %0d", e);
      return;
    end
    len  = exp_len[e].pop_front();
    lwdv = exp_lwdv[e].pop_front();
    o_packets++;
    if (got_words.size() != len) begin
      o_errors++;
      $display("Fail packet length expected %h got %h", len, got_words.size());
    end
    for (int i = 0; i < len; i++) begin
      src = exp_words[e].pop_front();
      if (i >= got_words.size()) begin
        continue;
      end
      n        = (i == len - 1) ? int'(lwdv) : 8;
      exp_mask = low_ones(n);
      exp_data = swap_byte_order(src, n);
      if (got_masks[i] !== exp_mask) begin
        o_errors++;
        $display("Fail o_mac_tx_data_valid expected %h got %h", exp_mask, got_masks[i]);
      end
      if (got_words[i] !== exp_data) begin
        o_errors++;
        $display("Fail o_mac_tx_data expected %h got %h", exp_data, got_words[i]);
      end
    end
  endtask

  always @(posedge i_clk) begin
    if (i_areset) begin
      collecting = 1'b0;
      holding    = 1'b0;
      for (int e = 0; e < ENGINES; e++) begin
        stream_cnt[e] = 0;
        busy[e]       = 1'b0;
      end
    end else begin
      // ----------------------------------------
      // Engine side builds the expected queues
      // ----------------------------------------
      busy_cnt = 0;
      for (int e = 0; e < ENGINES; e++) begin
        if (i_engine_fifo_rd_start[e]) begin
          if (busy[e] || !i_engines[e].packet_available || i_engines[e].fifo_empty) begin
            o_errors++;
            $display("Read start sent to engine %0d with no packet waiting", e);
          end
          busy[e] = 1'b1;
        end
        if (i_engines[e].rd_valid) begin
          exp_words[e].push_back(i_engines[e].rd_data);
          stream_cnt[e]++;
        end else if (stream_cnt[e] > 0) begin
          // Stream just ended so the packet is complete
          exp_len[e].push_back(stream_cnt[e]);
          exp_lwdv[e].push_back(i_engines[e].bytes_last_word);
          stream_cnt[e] = 0;
        end
        if (i_engine_packet_read[e]) begin
          if (!busy[e] || !i_engines[e].fifo_empty) begin
            o_errors++;
            $display("Packet read sent to engine %0d before its stream ended", e);
          end
          busy[e] = 1'b0;
        end
        if (busy[e]) begin
          busy_cnt++;
        end
      end
      if (busy_cnt > 1) begin
        o_errors++;
        $display("More than one engine is being read at the same time");
      end

      // ----------------------------------------
      // MAC side
      // ----------------------------------------
      if (i_mac_tx_start) begin
        if (collecting) begin
          o_errors++;
          $display("New packet started with no idle cycle after the previous one");
          compare_packet();
        end
        if (i_mac_tx_data_valid !== 8'hff) begin
          o_errors++;
          $display("Fail o_mac_tx_data_valid expected %h got %h", 8'hff, i_mac_tx_data_valid);
        end
        got_words.delete();
        got_masks.delete();
        got_words.push_back(i_mac_tx_data);
        got_masks.push_back(i_mac_tx_data_valid);
        first_word = i_mac_tx_data;
        collecting = 1'b1;
        holding    = !i_mac_tx_ack;
      end else if (holding) begin
        // Word 0 must not move before the acknowledge
        if (i_mac_tx_data !== first_word) begin
          o_errors++;
          $display("Fail o_mac_tx_data expected %h got %h", first_word, i_mac_tx_data);
        end
        if (i_mac_tx_data_valid !== 8'hff) begin
          o_errors++;
          $display("Fail o_mac_tx_data_valid expected %h got %h", 8'hff, i_mac_tx_data_valid);
        end
        holding = !i_mac_tx_ack;
      end else if (i_mac_tx_data_valid != 8'h00) begin
        if (!collecting) begin
          o_errors++;
          $display("Data word seen on the MAC without a start pulse");
        end else begin
          got_words.push_back(i_mac_tx_data);
          got_masks.push_back(i_mac_tx_data_valid);
        end
      end else if (collecting) begin
        compare_packet();
        collecting = 1'b0;
      end
    end
  end

  initial begin
    o_errors  = 0;
    o_packets = 0;
  end

endmodule

// ==== sim/tb_nts_extractor.sv ====
// Engines stream one word per cycle with no gaps and the MAC acknowledges within 3 cycles
`timescale 1ns/1ps

module tb_nts_extractor
  import nts_extractor_pkg::*;
();

  localparam int ENGINES            = 4;
  localparam int PACKETS_PER_ENGINE = 6;
  localparam int MAX_WORDS          = 64;
  localparam int RESET_CYCLES       = 5;
  localparam int TOTAL              = ENGINES * PACKETS_PER_ENGINE;
  localparam int LIMIT = ENGINES * PACKETS_PER_ENGINE * (MAX_WORDS + 20) + RESET_CYCLES;

  // Engine model states
  localparam int EM_GAP    = 0;
  localparam int EM_READY  = 1;
  localparam int EM_STREAM = 2;
  localparam int EM_DONE   = 3;

  logic                     i_clk;
  logic                     i_areset;
  engine_if_t [ENGINES-1:0] engines;
  logic       [ENGINES-1:0] rd_start;
  logic       [ENGINES-1:0] packet_read;
  logic                     mac_start;
  logic                     mac_ack;
  byte_mask_t               mac_valid;
  word_t                    mac_data;
  int                       errors;
  int                       packets;
  int                       cycles;
  integer                   seed;

  int          pkt_len [ENGINES][PACKETS_PER_ENGINE];
  byte_count_t pkt_lwdv [ENGINES][PACKETS_PER_ENGINE];
  word_t       pkt_word [ENGINES][PACKETS_PER_ENGINE][MAX_WORDS];
  int          eng_state [ENGINES];
  int          pkt_idx [ENGINES];
  int          word_idx [ENGINES];
  int          gap_cnt [ENGINES];
  int          ack_wait;
  logic        ack_pending;
  logic        timed_out;

  nts_extractor #(
    .ENGINES(ENGINES)
  ) nts_extractor_inst (
    .i_clk                  (i_clk),
    .i_areset               (i_areset),
    .i_engines              (engines),
    .o_engine_fifo_rd_start (rd_start),
    .o_engine_packet_read   (packet_read),
    .o_mac_tx_start         (mac_start),
    .i_mac_tx_ack           (mac_ack),
    .o_mac_tx_data_valid    (mac_valid),
    .o_mac_tx_data          (mac_data)
  );

  extractor_checker #(
    .ENGINES(ENGINES)
  ) extractor_checker_inst (
    .i_clk                  (i_clk),
    .i_areset               (i_areset),
    .i_engines              (engines),
    .i_engine_fifo_rd_start (rd_start),
    .i_engine_packet_read   (packet_read),
    .i_mac_tx_start         (mac_start),
    .i_mac_tx_ack           (mac_ack),
    .i_mac_tx_data_valid    (mac_valid),
    .i_mac_tx_data          (mac_data),
    .o_errors               (errors),
    .o_packets              (packets)
  );

  always #5 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
  end

  task automatic generate_packets();
    for (int e = 0; e < ENGINES; e++) begin
      for (int p = 0; p < PACKETS_PER_ENGINE; p++) begin
        pkt_len[e][p]  = 2 + int'($unsigned($random(seed)) % (MAX_WORDS - 1));
        pkt_lwdv[e][p] = byte_count_t'(1 + $unsigned($random(seed)) % 8);
        for (int w = 0; w < MAX_WORDS; w++) begin
          pkt_word[e][p][w] = {$random(seed), $random(seed)};
        end
        // Word 0 names its engine so the checker can find the queue
        pkt_word[e][p][0][7:0] = 8'(e);
      end
    end
  endtask

  // ----------------------------------------
  // Engine FIFO models
  // ----------------------------------------
  task automatic step_engines();
    for (int e = 0; e < ENGINES; e++) begin
      case (eng_state[e])
        EM_GAP: begin
          if (gap_cnt[e] > 0) begin
            gap_cnt[e]--;
          end else if (pkt_idx[e] < PACKETS_PER_ENGINE) begin
            engines[e].packet_available = 1'b1;
            engines[e].fifo_empty       = 1'b0;
            engines[e].bytes_last_word  = pkt_lwdv[e][pkt_idx[e]];
            eng_state[e]                = EM_READY;
          end
        end
        EM_READY: begin
          if (rd_start[e]) begin
            engines[e].rd_valid = 1'b1;
            engines[e].rd_data  = pkt_word[e][pkt_idx[e]][0];
            word_idx[e]         = 1;
            eng_state[e]        = EM_STREAM;
          end
        end
        EM_STREAM: begin
          if (word_idx[e] < pkt_len[e][pkt_idx[e]]) begin
            engines[e].rd_data = pkt_word[e][pkt_idx[e]][word_idx[e]];
            word_idx[e]++;
          end else begin
            engines[e].rd_valid   = 1'b0;
            engines[e].fifo_empty = 1'b1;
            eng_state[e]          = EM_DONE;
          end
        end
        default: begin
          if (packet_read[e]) begin
            engines[e].packet_available = 1'b0;
            pkt_idx[e]++;
            gap_cnt[e]   = 1 + int'($unsigned($random(seed)) % 3);
            eng_state[e] = EM_GAP;
          end
        end
      endcase
    end
  endtask

  task automatic step_ack();
    mac_ack = 1'b0;
    if (mac_start) begin
      ack_wait    = int'($unsigned($random(seed)) % 4);
      ack_pending = 1'b1;
    end
    if (ack_pending) begin
      if (ack_wait == 0) begin
        mac_ack     = 1'b1;
        ack_pending = 1'b0;
      end else begin
        ack_wait--;
      end
    end
  endtask

  initial begin
    seed        = 32'h0a77_e4a7;
    i_clk       = 1'b0;
    i_areset    = 1'b1;
    engines     = '0;
    mac_ack     = 1'b0;
    cycles      = 0;
    ack_wait    = 0;
    ack_pending = 1'b0;
    for (int e = 0; e < ENGINES; e++) begin
      engines[e].fifo_empty = 1'b1;
      eng_state[e]          = EM_GAP;
      pkt_idx[e]            = 0;
      word_idx[e]           = 0;
      gap_cnt[e]            = 0;
    end
    generate_packets();
    repeat (RESET_CYCLES) @(posedge i_clk);
    #1 i_areset = 1'b0;

    while (packets < TOTAL && cycles < LIMIT) begin
      @(posedge i_clk);
      #1;
      step_engines();
      step_ack();
    end
    // A few more cycles to catch any extra packet
    repeat (20) begin
      @(posedge i_clk);
      #1;
      step_engines();
      step_ack();
    end

    timed_out = packets < TOTAL;
    if (timed_out) begin
      $display("Timeout: only %0d of %0d packets arrived within %0d cycles",
               packets, TOTAL, LIMIT);
    end
    $display("Errors: %0d, packets received: %0d of %0d", errors, packets, TOTAL);
    if (errors == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== nts_extractor.f ====
src/nts_extractor_pkg.sv
src/engine_mux.sv
src/engine_reader.sv
src/tx_slot_ring.sv
src/mac_tx.sv
src/nts_extractor.sv
sim/extractor_checker.sv
sim/tb_nts_extractor.sv

// ==== Makefile ====
# Verilator build for the packet extractor testbench

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f nts_extractor.f --top-module tb_nts_extractor
	verilator --lint-only -f nts_extractor.f --top-module nts_extractor

sim:
	verilator --binary --timing --assert -f nts_extractor.f --top-module tb_nts_extractor \
		--Mdir $(OBJ_DIR) -o tb_nts_extractor
	./$(OBJ_DIR)/tb_nts_extractor 2>&1 | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "Simulation FAILED"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
